/* hw/mac_rx_pkg.sv */
/*
 * RMII receive MAC, shared definitions
 * preamble pattern, CRC-32 constants and the frame FIFO word
 */
package mac_rx_pkg;

	// --------------------------------------------------------------------------
	// framing
	// --------------------------------------------------------------------------

	// seven 0x55 bytes then 0xd5, as the dibit shift register holds them
	// dibits enter at the top, so the sfd byte lands in the msbs
	localparam logic [63:0] MAC_PREAMBLE_SFD = 64'hd555_5555_5555_5555;

	// --------------------------------------------------------------------------
	// crc-32, lsb first
	// --------------------------------------------------------------------------

	// reflected form of 0x04c11db7
	localparam logic [31:0] CRC32_POLY    = 32'hedb8_8320;
	localparam logic [31:0] CRC32_INIT    = 32'hffff_ffff;
	// register value once a frame and its own fcs have passed
	// no final inversion applied
	localparam logic [31:0] CRC32_RESIDUE = 32'hdebb_20e3;

	// --------------------------------------------------------------------------
	// fifo word
	// --------------------------------------------------------------------------

	// one received byte plus its frame markers
	// crc_err and len_err only carry meaning with eop
	typedef struct packed {
		logic       sop;
		logic       eop;
		logic       crc_err;
		logic       len_err;
		logic [7:0] data;
	} mac_rx_word_t;

endpackage

/* hw/mac_rx_deframer.sv */
/*
 * RMII receive deframer
 * finds preamble and sfd in the dibit stream, assembles bytes low dibit
 * first, ends the frame on idle or on the length limit, and holds one
 * byte back so the end markers sit on the real last byte
 */
`timescale 1ns/10ps

module mac_rx_deframer #(
	parameter int MAX_FRAME_BYTES = 1518,
	parameter int IDLE_LIMIT      = 48
) (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_rmii_rxvld,
	input  logic [1:0]               i_rmii_rxdata,
	input  logic                     i_crc_ok,
	output logic                     o_crc_start,
	output logic                     o_byte_stb,
	output logic [7:0]               o_byte,
	output logic                     o_wr_en,
	output mac_rx_pkg::mac_rx_word_t o_wr_word
);
	import mac_rx_pkg::*;

	localparam int BYTE_CNT_W = $clog2(MAX_FRAME_BYTES);
	localparam int IDLE_CNT_W = $clog2(IDLE_LIMIT + 1);

	// input delay line, stage 0 feeds the sfd search, stage 2 the byte path
	logic [2:0]            r_vld_d;
	logic [2:0][1:0]       r_data_d;
	logic [63:0]           r_shift;
	logic                  r_sfd_hit;
	logic                  r_open;
	logic                  r_discard;
	logic [IDLE_CNT_W-1:0] r_idle_cnt;
	logic [BYTE_CNT_W-1:0] r_byte_cnt;
	logic [1:0]            r_dibit_cnt;
	logic [5:0]            r_asm;
	logic                  r_first;
	logic [7:0]            r_hold;
	logic                  r_hold_sop;
	logic                  r_hold_vld;
	logic                  r_end_pend;
	logic                  r_end_len;
	logic                  r_byte_stb;
	logic [7:0]            r_byte;
	logic                  r_wr_en;
	mac_rx_word_t          r_wr_word;

	logic                  w_open;
	logic                  w_idle_done;
	logic                  w_idle_hit;
	logic                  w_take;
	logic                  w_byte_done;
	logic                  w_limit_hit;
	logic [7:0]            w_byte_new;

	// new frame only from idle, never while a cut frame drains
	assign w_open      = r_sfd_hit && !r_open && !r_discard;
	assign w_idle_done = (r_idle_cnt == IDLE_CNT_W'(IDLE_LIMIT));
	assign w_idle_hit  = r_open && w_idle_done;
	assign w_take      = r_open && r_vld_d[2] && !w_idle_done;
	assign w_byte_done = w_take && (r_dibit_cnt == 2'd3);
	// fourth dibit goes on top of the three already collected
	assign w_byte_new  = {r_data_d[2], r_asm};
	assign w_limit_hit = w_byte_done &&
		(r_byte_cnt == BYTE_CNT_W'(MAX_FRAME_BYTES - 1));

	// --------------------------------------------------------------------------
	// input registers and sfd search
	// --------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_vld_d <= '0;
		end else begin
			r_vld_d <= {r_vld_d[1:0], i_rmii_rxvld};
		end
	end

	always_ff @(posedge i_clk) begin
		r_data_d <= {r_data_d[1:0], i_rmii_rxdata};
	end

	// shift right, newest dibit at the top
	// cleared at frame start so payload cannot look like a preamble
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_shift   <= '0;
			r_sfd_hit <= 1'b0;
		end else begin
			if (w_open)
				r_shift <= '0;
			else if (r_vld_d[0])
				r_shift <= {r_data_d[0], r_shift[63:2]};
			r_sfd_hit <= (r_shift == MAC_PREAMBLE_SFD);
		end
	end

	// --------------------------------------------------------------------------
	// frame tracking
	// --------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_open     <= 1'b0;
			r_discard  <= 1'b0;
			r_idle_cnt <= '0;
		end else begin
			if (w_open)
				r_open <= 1'b1;
			else if (w_idle_hit || w_limit_hit)
				r_open <= 1'b0;

			// after a cut, swallow the tail until the line goes quiet
			if (w_limit_hit)
				r_discard <= 1'b1;
			else if (r_discard && w_idle_done)
				r_discard <= 1'b0;

			// idle run length, saturates at the limit
			if (w_open || r_vld_d[2] || !(r_open || r_discard))
				r_idle_cnt <= '0;
			else if (!w_idle_done)
				r_idle_cnt <= r_idle_cnt + 1'b1;
		end
	end

	// --------------------------------------------------------------------------
	// byte assembly and hold
	// --------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_dibit_cnt <= 2'd0;
			r_byte_cnt  <= '0;
			r_first     <= 1'b0;
		end else if (w_open) begin
			r_dibit_cnt <= 2'd0;
			r_byte_cnt  <= '0;
			r_first     <= 1'b1;
		end else if (w_take) begin
			// wraps after four dibits
			r_dibit_cnt <= r_dibit_cnt + 2'd1;
			if (w_byte_done) begin
				r_byte_cnt <= r_byte_cnt + 1'b1;
				r_first    <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_take)
			r_asm <= w_byte_new[7:2];
	end

	// last byte waits here until the next byte or the frame end
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_hold_vld <= 1'b0;
		end else if (w_byte_done) begin
			r_hold_vld <= 1'b1;
		end else if (r_end_pend) begin
			r_hold_vld <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_byte_done) begin
			r_hold     <= w_byte_new;
			r_hold_sop <= r_first;
			r_byte     <= w_byte_new;
		end
	end

	// --------------------------------------------------------------------------
	// crc feed and fifo write
	// --------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_end_pend <= 1'b0;
			r_end_len  <= 1'b0;
			r_byte_stb <= 1'b0;
			r_wr_en    <= 1'b0;
		end else begin
			r_end_pend <= w_idle_hit || w_limit_hit;
			r_end_len  <= w_limit_hit;
			r_byte_stb <= w_byte_done;
			// nothing to write for a frame with no whole byte
			r_wr_en    <= (r_end_pend || w_byte_done) && r_hold_vld;
		end
	end

	// a cut frame never ends on its real fcs, so it is always flagged
	always_ff @(posedge i_clk) begin
		r_wr_word.sop     <= r_hold_sop;
		r_wr_word.eop     <= r_end_pend;
		r_wr_word.crc_err <= r_end_pend && (r_end_len || !i_crc_ok);
		r_wr_word.len_err <= r_end_pend && r_end_len;
		r_wr_word.data    <= r_hold;
	end

	assign o_crc_start = w_open;
	assign o_byte_stb  = r_byte_stb;
	assign o_byte      = r_byte;
	assign o_wr_en     = r_wr_en;
	assign o_wr_word   = r_wr_word;

endmodule

/* hw/mac_rx_crc32.sv */
/*
 * RMII receive CRC-32 checker
 * bytewise reflected crc over every received byte, fcs included
 * a match against the fixed residue means the fcs was good
 */
`timescale 1ns/10ps

module mac_rx_crc32 (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_start,
	input  logic       i_byte_stb,
	input  logic [7:0] i_byte,
	output logic       o_crc_ok
);
	import mac_rx_pkg::*;

	logic [31:0] r_crc;
	logic [31:0] w_crc_next;

	// --------------------------------------------------------------------------
	// one byte, lsb first, eight steps in one cycle
	// --------------------------------------------------------------------------
	function automatic logic [31:0] crc32_byte(
		input logic [31:0] crc,
		input logic [7:0]  data
	);
		logic [31:0] c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			// feedback is the register lsb against the incoming bit
			if (c[0] ^ data[i])
				c = (c >> 1) ^ CRC32_POLY;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	assign w_crc_next = crc32_byte(r_crc, i_byte);

	// --------------------------------------------------------------------------
	// running register
	// --------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_crc <= CRC32_INIT;
		end else if (i_start) begin
			// reload at every sfd
			r_crc <= CRC32_INIT;
		end else if (i_byte_stb) begin
			r_crc <= w_crc_next;
		end
	end

	// level, valid at any point in the frame
	// only meaningful once the last fcs byte is in
	assign o_crc_ok = (r_crc == CRC32_RESIDUE);

endmodule

/* hw/mac_rx_frame_buffer.sv */
/*
 * RMII receive frame buffer
 * ram fifo of frame words, drained whenever it holds data
 * registered ram read, then registered output strobes
 */
`timescale 1ns/10ps

module mac_rx_frame_buffer #(
	parameter int FIFO_DEPTH = 512
) (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_wr_en,
	input  mac_rx_pkg::mac_rx_word_t i_wr_word,
	output logic                     o_sop,
	output logic                     o_eop,
	output logic                     o_vld,
	output logic [7:0]               o_data,
	output logic                     o_crc_err,
	output logic                     o_len_err
);
	import mac_rx_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	mac_rx_word_t r_mem [FIFO_DEPTH];
	// one extra bit tells full from empty
	logic [AW:0]  r_wr_ptr;
	logic [AW:0]  r_rd_ptr;
	mac_rx_word_t r_ram_q;
	logic         r_rd_vld;
	logic         r_sop;
	logic         r_eop;
	logic         r_vld;
	logic [7:0]   r_data;
	logic         r_crc_err;
	logic         r_len_err;

	logic         w_full;
	logic         w_empty;
	logic         w_wr_ok;
	logic         w_rd_en;

	assign w_empty = (r_wr_ptr == r_rd_ptr);
	assign w_full  = (r_wr_ptr[AW] != r_rd_ptr[AW]) &&
		(r_wr_ptr[AW-1:0] == r_rd_ptr[AW-1:0]);
	// writes into a full buffer are lost
	assign w_wr_ok = i_wr_en && !w_full;
	// drain side has no stall
	assign w_rd_en = !w_empty;

	// --------------------------------------------------------------------------
	// storage and pointers
	// --------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (w_wr_ok)
			r_mem[r_wr_ptr[AW-1:0]] <= i_wr_word;
	end

	always_ff @(posedge i_clk) begin
		if (w_rd_en)
			r_ram_q <= r_mem[r_rd_ptr[AW-1:0]];
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_rd_vld <= 1'b0;
		end else begin
			if (w_wr_ok)
				r_wr_ptr <= r_wr_ptr + 1'b1;
			if (w_rd_en)
				r_rd_ptr <= r_rd_ptr + 1'b1;
			// marks r_ram_q as fresh
			r_rd_vld <= w_rd_en;
		end
	end

	// --------------------------------------------------------------------------
	// output stage
	// --------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_vld     <= 1'b0;
			r_sop     <= 1'b0;
			r_eop     <= 1'b0;
			r_crc_err <= 1'b0;
			r_len_err <= 1'b0;
		end else begin
			r_vld     <= r_rd_vld;
			r_sop     <= r_rd_vld && r_ram_q.sop;
			r_eop     <= r_rd_vld && r_ram_q.eop;
			r_crc_err <= r_rd_vld && r_ram_q.crc_err;
			r_len_err <= r_rd_vld && r_ram_q.len_err;
		end
	end

	always_ff @(posedge i_clk) begin
		r_data <= r_ram_q.data;
	end

	assign o_sop     = r_sop;
	assign o_eop     = r_eop;
	assign o_vld     = r_vld;
	assign o_data    = r_data;
	assign o_crc_err = r_crc_err;
	assign o_len_err = r_len_err;

endmodule

/* hw/mac_rx.sv */
/*
 * RMII receive MAC, top level
 * deframer, fcs checker and frame buffer in a chain
 * output is a byte stream with sop, eop, valid and error flags
 */
`timescale 1ns/10ps

module mac_rx #(
	parameter int MAX_FRAME_BYTES = 1518,
	parameter int IDLE_LIMIT      = 48,
	parameter int FIFO_DEPTH      = 512
) (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_rmii_rxvld,
	input  logic [1:0] i_rmii_rxdata,
	output logic       o_sop,
	output logic       o_eop,
	output logic       o_vld,
	output logic [7:0] o_data,
	output logic       o_crc_err,
	output logic       o_len_err
);
	import mac_rx_pkg::*;

	// deframer to crc
	logic         w_crc_start;
	logic         w_byte_stb;
	logic [7:0]   w_byte;
	logic         w_crc_ok;
	// deframer to buffer
	logic         w_wr_en;
	mac_rx_word_t w_wr_word;

	mac_rx_deframer #(
		.MAX_FRAME_BYTES (MAX_FRAME_BYTES),
		.IDLE_LIMIT      (IDLE_LIMIT)
	) u_deframer (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_rmii_rxvld  (i_rmii_rxvld),
		.i_rmii_rxdata (i_rmii_rxdata),
		.i_crc_ok      (w_crc_ok),
		.o_crc_start   (w_crc_start),
		.o_byte_stb    (w_byte_stb),
		.o_byte        (w_byte),
		.o_wr_en       (w_wr_en),
		.o_wr_word     (w_wr_word)
	);

	mac_rx_crc32 u_crc32 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (w_crc_start),
		.i_byte_stb (w_byte_stb),
		.i_byte     (w_byte),
		.o_crc_ok   (w_crc_ok)
	);

	// outputs straight from the buffer registers
	mac_rx_frame_buffer #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_frame_buffer (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_en   (w_wr_en),
		.i_wr_word (w_wr_word),
		.o_sop     (o_sop),
		.o_eop     (o_eop),
		.o_vld     (o_vld),
		.o_data    (o_data),
		.o_crc_err (o_crc_err),
		.o_len_err (o_len_err)
	);

endmodule

/* dv/mac_rx_props.sv */
/*
 * frame buffer properties
 * fifo flag sanity and output strobe relations
 */
`timescale 1ns/10ps

module mac_rx_props #(
	parameter int PTR_W = 10
) (
	input logic             i_clk,
	input logic             i_rst_n,
	input logic             i_wr_en,
	input logic             i_full,
	input logic [PTR_W-1:0] i_wr_ptr,
	input logic [PTR_W-1:0] i_rd_ptr,
	input logic             i_vld,
	input logic             i_sop,
	input logic             i_eop,
	input logic             i_crc_err,
	input logic             i_len_err
);

	// bytes come at most every four cycles, drain never stalls
	a_no_wr_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_wr_en && i_full))
		else $error("write into a full frame buffer");

	// read pointer only moves on past a word that was written
	a_no_rd_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_rd_ptr != $past(i_rd_ptr)) |-> ($past(i_rd_ptr) != $past(i_wr_ptr)))
		else $error("read from an empty frame buffer");

	// strobes only ride on a valid byte
	a_sop_vld: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_sop |-> i_vld)
		else $error("sop without valid");

	a_eop_vld: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_eop |-> i_vld)
		else $error("eop without valid");

	a_err_vld: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_crc_err || i_len_err) |-> i_vld)
		else $error("error flag without valid");

	// error flags belong to the last byte
	a_err_eop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_crc_err || i_len_err) |-> i_eop)
		else $error("error flag away from eop");

endmodule

bind mac_rx_frame_buffer mac_rx_props #(
	.PTR_W (AW + 1)
) i_props (
	.i_clk     (i_clk),
	.i_rst_n   (i_rst_n),
	.i_wr_en   (i_wr_en),
	.i_full    (w_full),
	.i_wr_ptr  (r_wr_ptr),
	.i_rd_ptr  (r_rd_ptr),
	.i_vld     (o_vld),
	.i_sop     (o_sop),
	.i_eop     (o_eop),
	.i_crc_err (o_crc_err),
	.i_len_err (o_len_err)
);

/* dv/tb_mac_rx.sv */
/*
 * testbench for the RMII receive MAC
 * directed frames through an RMII dibit driver, its own FCS model,
 * an output collector and a watchdog
 */
`timescale 1ns/10ps

module tb_mac_rx;
	import mac_rx_pkg::*;

	localparam int MAX_FRAME_BYTES = 128;
	localparam int IDLE_LIMIT      = 48;
	localparam int FIFO_DEPTH      = 512;
	// shortest legal gap between frames
	localparam int GAP_CYCLES      = IDLE_LIMIT + 2;
	localparam int WAIT_CYCLES     = 200;

	typedef logic [7:0] bytes_t [$];

	logic         i_clk = 1'b0;
	logic         i_rst_n;
	logic         i_rmii_rxvld;
	logic [1:0]   i_rmii_rxdata;
	logic         o_sop;
	logic         o_eop;
	logic         o_vld;
	logic [7:0]   o_data;
	logic         o_crc_err;
	logic         o_len_err;

	// everything the DUT put out, in order
	mac_rx_word_t rx_q [$];
	int           eop_cnt = 0;
	int           err_cnt = 0;
	int           test_cnt = 0;
	int           test_fail_cnt = 0;
	int           b2b_len [5];
	bytes_t       good_q;

	always #10 i_clk = ~i_clk;

	mac_rx #(
		.MAX_FRAME_BYTES (MAX_FRAME_BYTES),
		.IDLE_LIMIT      (IDLE_LIMIT),
		.FIFO_DEPTH      (FIFO_DEPTH)
	) i_mac_rx (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_rmii_rxvld  (i_rmii_rxvld),
		.i_rmii_rxdata (i_rmii_rxdata),
		.o_sop         (o_sop),
		.o_eop         (o_eop),
		.o_vld         (o_vld),
		.o_data        (o_data),
		.o_crc_err     (o_crc_err),
		.o_len_err     (o_len_err)
	);

	// output collector
	always @(posedge i_clk) begin
		if (o_vld) begin
			rx_q.push_back(mac_rx_word_t'({o_sop, o_eop, o_crc_err, o_len_err, o_data}));
			if (o_eop)
				eop_cnt++;
		end
	end

	// --------------------------------------------------------------------------
	// frame model and RMII driver
	// --------------------------------------------------------------------------

	// ethernet fcs, reflected, init all ones, inverted at the end
	function automatic logic [31:0] frame_fcs(input bytes_t data);
		logic [31:0] crc;
		logic        fb;
		crc = 32'hffff_ffff;
		foreach (data[i]) begin
			for (int b = 0; b < 8; b++) begin
				fb  = crc[0] ^ data[i][b];
				crc = {1'b0, crc[31:1]} ^ ({32{fb}} & 32'hedb8_8320);
			end
		end
		return ~crc;
	endfunction

	// fcs goes out low byte first
	task automatic append_fcs(inout bytes_t frame);
		logic [31:0] fcs;
		fcs = frame_fcs(frame);
		for (int k = 0; k < 4; k++)
			frame.push_back(fcs[8*k +: 8]);
	endtask

	task automatic random_bytes(input int n, output bytes_t q);
		q.delete();
		repeat (n)
			q.push_back(8'($urandom));
	endtask

	// low dibit first
	task automatic drive_byte(input logic [7:0] b);
		for (int i = 0; i < 4; i++) begin
			@(posedge i_clk);
			#2;
			i_rmii_rxvld  = 1'b1;
			i_rmii_rxdata = b[2*i +: 2];
		end
	endtask

	task automatic send_frame(input bytes_t frame, input logic [7:0] sfd);
		repeat (7)
			drive_byte(8'h55);
		drive_byte(sfd);
		foreach (frame[i])
			drive_byte(frame[i]);
		@(posedge i_clk);
		#2;
		i_rmii_rxvld  = 1'b0;
		i_rmii_rxdata = 2'b00;
		repeat (GAP_CYCLES - 1)
			@(posedge i_clk);
	endtask

	// --------------------------------------------------------------------------
	// checking
	// --------------------------------------------------------------------------
	task automatic check_eq(input string test, input string what, input int exp, input int act);
		assert (exp == act) else begin
			$display("Fail %s: %s expected 0x%0h actual 0x%0h", test, what, exp, act);
			err_cnt++;
		end
	endtask

	task automatic wait_frames(input string test, input int target);
		int cycles;
		cycles = 0;
		while (eop_cnt < target && cycles < WAIT_CYCLES) begin
			@(posedge i_clk);
			#2;
			cycles++;
		end
		assert (eop_cnt >= target) else begin
			$display("%s: timed out waiting for the end of a frame", test);
			err_cnt++;
		end
	endtask

	// one frame from pos up to the next eop, pos moves past it
	task automatic check_frame(input string test, input bytes_t exp, input logic exp_crc,
			input logic exp_len, inout int pos);
		int last;
		int len;
		int n;
		last = pos;
		while (last < rx_q.size() && !rx_q[last].eop)
			last++;
		assert (last < rx_q.size()) else begin
			$display("%s: no end of frame in the output after word %0d", test, pos);
			err_cnt++;
		end
		if (last < rx_q.size()) begin
			len = last - pos + 1;
			check_eq(test, "frame length", exp.size(), len);
			n = (exp.size() < len) ? exp.size() : len;
			for (int i = 0; i < n; i++) begin
				check_eq(test, $sformatf("byte %0d", i), int'(exp[i]),
					int'(rx_q[pos + i].data));
				check_eq(test, $sformatf("sop on byte %0d", i), (i == 0) ? 1 : 0,
					int'(rx_q[pos + i].sop));
			end
			check_eq(test, "crc_err on eop", int'(exp_crc), int'(rx_q[last].crc_err));
			check_eq(test, "len_err on eop", int'(exp_len), int'(rx_q[last].len_err));
			pos = last + 1;
		end
	endtask

	task automatic finish_test(input string test, input int err_before);
		test_cnt++;
		if (err_cnt == err_before) begin
			$display("test %s: ok", test);
		end else begin
			test_fail_cnt++;
			$display("test %s: %0d failed checks", test, err_cnt - err_before);
		end
	endtask

	// --------------------------------------------------------------------------
	// tests
	// --------------------------------------------------------------------------
	task automatic reset_idle();
		int err0;
		int hi;
		err0 = err_cnt;
		hi = 0;
		repeat (100) begin
			@(posedge i_clk);
			#2;
			if (o_vld)
				hi++;
		end
		check_eq("reset_idle", "o_vld high cycles", 0, hi);
		finish_test("reset_idle", err0);
	endtask

	task automatic good_frame();
		int     err0;
		int     pos;
		int     target;
		bytes_t frame;
		err0   = err_cnt;
		pos    = rx_q.size();
		target = eop_cnt + 1;
		random_bytes(64, frame);
		append_fcs(frame);
		good_q = frame;
		send_frame(frame, 8'hd5);
		wait_frames("good_frame", target);
		check_frame("good_frame", frame, 1'b0, 1'b0, pos);
		finish_test("good_frame", err0);
	endtask

	// same bytes as the good frame, one fcs bit flipped
	task automatic bad_fcs();
		int     err0;
		int     pos;
		int     target;
		int     flip;
		bytes_t frame;
		err0   = err_cnt;
		pos    = rx_q.size();
		target = eop_cnt + 1;
		frame  = good_q;
		flip   = int'($urandom % 32);
		frame[64 + flip / 8] = frame[64 + flip / 8] ^ (8'h01 << (flip % 8));
		send_frame(frame, 8'hd5);
		wait_frames("bad_fcs", target);
		check_frame("bad_fcs", frame, 1'b1, 1'b0, pos);
		finish_test("bad_fcs", err0);
	endtask

	task automatic bad_preamble();
		int     err0;
		int     pos;
		bytes_t frame;
		err0 = err_cnt;
		pos  = rx_q.size();
		random_bytes(64, frame);
		// a zero dibit breaks the 0x55 run, no late sfd match
		frame[0] = 8'h00;
		append_fcs(frame);
		send_frame(frame, 8'h55);
		repeat (WAIT_CYCLES)
			@(posedge i_clk);
		#2;
		check_eq("bad_preamble", "output bytes", 0, rx_q.size() - pos);
		finish_test("bad_preamble", err0);
	endtask

	// cut at the limit, then a clean frame behind it
	task automatic oversize_frame();
		int     err0;
		int     pos;
		int     target;
		bytes_t frame;
		bytes_t exp;
		err0   = err_cnt;
		pos    = rx_q.size();
		target = eop_cnt + 1;
		random_bytes(200, frame);
		for (int i = 0; i < MAX_FRAME_BYTES; i++)
			exp.push_back(frame[i]);
		send_frame(frame, 8'hd5);
		wait_frames("oversize_frame", target);
		check_frame("oversize_frame", exp, 1'b1, 1'b1, pos);
		target = eop_cnt + 1;
		random_bytes(64, frame);
		append_fcs(frame);
		send_frame(frame, 8'hd5);
		wait_frames("oversize_frame", target);
		check_frame("oversize_frame", frame, 1'b0, 1'b0, pos);
		finish_test("oversize_frame", err0);
	endtask

	task automatic back_to_back();
		int     err0;
		int     pos;
		int     target;
		bytes_t frames [5];
		err0   = err_cnt;
		pos    = rx_q.size();
		target = eop_cnt + 5;
		for (int f = 0; f < 5; f++) begin
			random_bytes(b2b_len[f], frames[f]);
			append_fcs(frames[f]);
		end
		for (int f = 0; f < 5; f++)
			send_frame(frames[f], 8'hd5);
		wait_frames("back_to_back", target);
		for (int f = 0; f < 5; f++)
			check_frame("back_to_back", frames[f], 1'b0, 1'b0, pos);
		finish_test("back_to_back", err0);
	endtask

	task automatic watchdog(input int cycles);
		repeat (cycles)
			@(posedge i_clk);
		$display("watchdog expired after %0d cycles, the tests did not complete", cycles);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	initial begin
		int total_bytes;
		int limit;
		i_rst_n       = 1'b0;
		i_rmii_rxvld  = 1'b0;
		i_rmii_rxdata = 2'b00;
		void'($urandom(32'h005fbd38));
		foreach (b2b_len[i])
			b2b_len[i] = 64 + int'($urandom % 57);
		// four 68 byte frames, the cut one, then preambles of all ten
		total_bytes = 4 * 68 + 200 + 10 * 8;
		foreach (b2b_len[i])
			total_bytes += b2b_len[i] + 4;
		limit = total_bytes * 4 * 3 / 2 + 10000;
		fork
			watchdog(limit);
		join_none
		repeat (16)
			@(posedge i_clk);
		#2;
		i_rst_n = 1'b1;

		reset_idle();
		good_frame();
		bad_fcs();
		bad_preamble();
		oversize_frame();
		back_to_back();

		$display("tests run %0d, tests failed %0d, failed checks %0d",
			test_cnt, test_fail_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* verilog.f */
hw/mac_rx_pkg.sv
hw/mac_rx_deframer.sv
hw/mac_rx_crc32.sv
hw/mac_rx_frame_buffer.sv
hw/mac_rx.sv
dv/mac_rx_props.sv
dv/tb_mac_rx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mac_rx testbench with verilator
# exit status is zero only when the testbench reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_mac_rx \
	-f verilog.f ||
	{ echo "build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_mac_rx 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -q "^TESTBENCH PASSED$" &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
